// ==== hdl/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// cpu side bus widths
`define BUS_ADDR_W 64
`define BUS_DATA_W 64

// on-chip ram geometry
`define WORD_W 32
`define RAM_WORDS 1024
// log2 of RAM_WORDS
`define RAM_IDX_W 10

// address map, byte addresses
`define RAM_BASE 64'h0000_0000_0000_1000

// keyboard character register, read only
`define KEY_ADDR 64'h0000_0000_0000_0F00

// console transmit strobe, write only
`define UART_ADDR 64'h0000_0000_0000_0F08

`endif

// ==== hdl/board_pkg.sv ====
`default_nettype none

`include "board_params.svh"

package board_pkg;

    // widths with a meaning on the bus
    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_data_t;
    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`RAM_IDX_W-1:0]  ram_idx_t;
    typedef logic [7:0]             byte_t;
    typedef logic [3:0]             irq_vec_t;

    // load type, stores reuse 0..3 as sb/sh/sw/sd
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } ls_type_e;

    // access controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_LO,
        ST_RD_HI,
        ST_RD_END,
        ST_WR_LO,
        ST_WR_HI,
        ST_IO_RD,
        ST_IO_WR
    } ctrl_state_e;

    // cpu request, held by the cpu until done
    typedef struct packed {
        bus_addr_t addr;
        ls_type_e  ls_type;
        bus_data_t wdata;
    } bus_req_t;

    // one ram beat
    typedef struct packed {
        logic       en;
        logic       we;
        logic [3:0] byte_en;
        ram_idx_t   idx;
        word_t      wdata;
    } ram_req_t;

endpackage

`default_nettype wire

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module word_ram (
    input  wire                      CLOCK_50,
    input  wire board_pkg::ram_req_t ram_req,
    output board_pkg::word_t         ram_rdata
);
    import board_pkg::*;

    localparam int LANES = `WORD_W / 8;

    // block ram, contents undefined at power up
    word_t mem [`RAM_WORDS];

    // write port, one enable per byte lane
    always_ff @(posedge CLOCK_50) begin
        if (ram_req.en && ram_req.we) begin
            for (int i = 0; i < LANES; i++) begin
                if (ram_req.byte_en[i]) begin
                    mem[ram_req.idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read
    // data is valid the cycle after the request
    always_ff @(posedge CLOCK_50) begin
        if (ram_req.en && !ram_req.we) begin
            ram_rdata <= mem[ram_req.idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/periph_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_regs (
    input  wire                    CLOCK_50,
    input  wire                    KEY0,
    input  wire                    key_pressed,
    input  wire board_pkg::byte_t  key_ascii,
    output board_pkg::byte_t       key_char,
    input  wire                    irq_ack,
    output board_pkg::irq_vec_t    irq_vec,
    input  wire                    tx_wr,
    input  wire board_pkg::byte_t  tx_byte,
    output logic                   tx_valid,
    output board_pkg::byte_t       tx_data
);
    import board_pkg::*;

    // keyboard is the only interrupt source
    localparam irq_vec_t KEY_IRQ = irq_vec_t'(1);

    logic key_d;
    logic key_edge;
    logic irq_set;
    logic irq_clr;

    // rising edge of the decoder strobe
    assign key_edge = key_pressed && !key_d;

    // any printable press raises the irq
    assign irq_set = key_pressed && (key_ascii != '0);
    assign irq_clr = irq_ack && (irq_vec != '0);

    // key edge detect and character latch
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_d    <= 1'b0;
            key_char <= '0;
        end else begin
            key_d <= key_pressed;
            if (key_edge) begin
                key_char <= key_ascii;
            end
        end
    end

    // one-deep interrupt
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vec <= '0;
        end else begin
            // ack beats a new press in the same cycle
            if (irq_clr) begin
                irq_vec <= '0;
            end else if (irq_set) begin
                irq_vec <= KEY_IRQ;
            end
        end
    end

    // console strobe, single cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tx_wr;
        end
    end

    // transmit byte, held until the next write
    always_ff @(posedge CLOCK_50) begin
        if (tx_wr) begin
            tx_data <= tx_byte;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module bus_ctrl (
    input  wire                   CLOCK_50,
    input  wire                   KEY0,
    input  wire board_pkg::bus_req_t req,
    input  wire                   read_en,
    input  wire                   write_en,
    output board_pkg::bus_data_t  rdata,
    output logic                  read_done,
    output logic                  write_done,
    output board_pkg::ram_req_t   ram_req,
    input  wire board_pkg::word_t ram_rdata,
    input  wire board_pkg::byte_t key_char,
    output logic                  tx_wr,
    output board_pkg::byte_t      tx_byte
);
    import board_pkg::*;

    ctrl_state_e state;
    bus_req_t    req_q;
    word_t       lo_q;
    bus_addr_t   ram_off;
    ram_idx_t    base_idx;
    logic [1:0]  byte_off;
    logic        beat_hi;
    logic        is_dbl;

    // ram window check, full byte range of the array
    function automatic logic in_ram(bus_addr_t a);
        return (a >= `RAM_BASE) && (a < (`RAM_BASE + (`RAM_WORDS * 4)));
    endfunction

    // lane mask from store type and byte offset
    function automatic logic [3:0] lane_mask(ls_type_e t, logic [1:0] off);
        case (t)
            LB:      return 4'b0001 << off;
            LH:      return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    // shift selected lanes down, then sign or zero extend
    function automatic bus_data_t extend_load(ls_type_e t, word_t w, logic [1:0] off);
        word_t s;
        s = w >> {off, 3'b000};
        case (t)
            LB:      return {{(`BUS_DATA_W-8){s[7]}}, s[7:0]};
            LH:      return {{(`BUS_DATA_W-16){s[15]}}, s[15:0]};
            LW:      return {{(`BUS_DATA_W-32){s[31]}}, s[31:0]};
            LBU:     return {{(`BUS_DATA_W-8){1'b0}}, s[7:0]};
            LHU:     return {{(`BUS_DATA_W-16){1'b0}}, s[15:0]};
            default: return {{(`BUS_DATA_W-32){1'b0}}, s[31:0]};
        endcase
    endfunction

    // word index and lane offset of the latched request
    assign ram_off  = req_q.addr - `RAM_BASE;
    assign base_idx = ram_off[`RAM_IDX_W+1:2];
    assign byte_off = req_q.addr[1:0];
    // ld and sd share code 3, two beats
    assign is_dbl   = (req_q.ls_type == LD);
    assign beat_hi  = (state == ST_RD_HI) || (state == ST_WR_HI);

    // ram beat, built from state and latched request
    always_comb begin
        ram_req         = '0;
        ram_req.en      = (state == ST_RD_LO) || (state == ST_RD_HI) ||
                          (state == ST_WR_LO) || (state == ST_WR_HI);
        ram_req.we      = (state == ST_WR_LO) || (state == ST_WR_HI);
        ram_req.idx     = base_idx + {{(`RAM_IDX_W-1){1'b0}}, beat_hi};
        ram_req.byte_en = lane_mask(req_q.ls_type, byte_off);
        // narrow stores replicate across lanes, byte_en picks the lane
        case (req_q.ls_type)
            LB:      ram_req.wdata = {4{req_q.wdata[7:0]}};
            LH:      ram_req.wdata = {2{req_q.wdata[15:0]}};
            default: ram_req.wdata = beat_hi ? req_q.wdata[63:32] : req_q.wdata[31:0];
        endcase
    end

    // console strobe, one cycle in the io write state
    assign tx_wr   = (state == ST_IO_WR) && (req_q.addr == `UART_ADDR);
    assign tx_byte = req_q.wdata[7:0];

    // request and low word capture
    always_ff @(posedge CLOCK_50) begin
        if ((state == ST_IDLE) && (read_en || write_en)) begin
            req_q <= req;
        end
        // first ld word arrives during the high beat
        if (state == ST_RD_HI) begin
            lo_q <= ram_rdata;
        end
    end

    // access sequencer and done flags
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            rdata      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // read wins if both pulse, cpu never does that
                    if (read_en) begin
                        read_done <= 1'b0;
                        state     <= in_ram(req.addr) ? ST_RD_LO : ST_IO_RD;
                    end else if (write_en) begin
                        write_done <= 1'b0;
                        state      <= in_ram(req.addr) ? ST_WR_LO : ST_IO_WR;
                    end
                end
                ST_RD_LO: begin
                    state <= is_dbl ? ST_RD_HI : ST_RD_END;
                end
                ST_RD_HI: begin
                    state <= ST_RD_END;
                end
                ST_RD_END: begin
                    // low word sits at the lower address
                    if (is_dbl) begin
                        rdata <= {ram_rdata, lo_q};
                    end else begin
                        rdata <= extend_load(req_q.ls_type, ram_rdata, byte_off);
                    end
                    read_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_WR_LO: begin
                    if (is_dbl) begin
                        state <= ST_WR_HI;
                    end else begin
                        write_done <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                ST_WR_HI: begin
                    write_done <= 1'b1;
                    state      <= ST_IDLE;
                end
                ST_IO_RD: begin
                    // unmapped reads give zero
                    if (req_q.addr == `KEY_ADDR) begin
                        rdata <= {{(`BUS_DATA_W-8){1'b0}}, key_char};
                    end else begin
                        rdata <= '0;
                    end
                    read_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_IO_WR: begin
                    // unmapped writes just complete
                    write_done <= 1'b1;
                    state      <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  wire                      CLOCK_50,
    input  wire                      KEY0,
    input  wire board_pkg::bus_req_t req,
    input  wire                      read_en,
    input  wire                      write_en,
    output board_pkg::bus_data_t     rdata,
    output logic                     read_done,
    output logic                     write_done,
    input  wire                      key_pressed,
    input  wire board_pkg::byte_t    key_ascii,
    input  wire                      irq_ack,
    output board_pkg::irq_vec_t      irq_vec,
    output logic                     tx_valid,
    output board_pkg::byte_t         tx_data
);
    import board_pkg::*;

    // controller to ram
    ram_req_t ram_req;
    word_t    ram_rdata;

    // controller to peripherals
    byte_t    key_char;
    logic     tx_wr;
    byte_t    tx_byte;

    bus_ctrl u_bus_ctrl (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .read_en    (read_en),
        .write_en   (write_en),
        .rdata      (rdata),
        .read_done  (read_done),
        .write_done (write_done),
        .ram_req    (ram_req),
        .ram_rdata  (ram_rdata),
        .key_char   (key_char),
        .tx_wr      (tx_wr),
        .tx_byte    (tx_byte)
    );

    word_ram u_word_ram (
        .CLOCK_50  (CLOCK_50),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    periph_regs u_periph_regs (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .key_ascii   (key_ascii),
        .key_char    (key_char),
        .irq_ack     (irq_ack),
        .irq_vec     (irq_vec),
        .tx_wr       (tx_wr),
        .tx_byte     (tx_byte),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data)
    );

endmodule

`default_nettype wire

// ==== dv/soc_bus_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module soc_bus_props (
    input wire                      CLOCK_50,
    input wire                      KEY0,
    input wire board_pkg::bus_req_t req,
    input wire                      read_en,
    input wire                      write_en,
    input wire                      read_done,
    input wire                      write_done,
    input wire                      tx_valid,
    input wire board_pkg::irq_vec_t irq_vec
);
    import board_pkg::*;

    logic in_ram;
    logic is_dbl;
    // number of failed properties so far
    int   fails = 0;

    // decode of the request presented with the enable
    assign in_ram = (req.addr >= `RAM_BASE) && (req.addr < (`RAM_BASE + (`RAM_WORDS * 4)));
    assign is_dbl = (req.ls_type == LD);

    // values right after a reset edge
    a_reset: assert property (@(posedge CLOCK_50)
        !KEY0 |=> read_done && write_done && !tx_valid && (irq_vec == '0))
        else begin
            $error("outputs not idle after reset");
            fails++;
        end

    // enables only while both done flags are high
    a_idle_req: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_en || write_en) |-> read_done && write_done)
        else begin
            $error("enable while an access is pending");
            fails++;
        end

    // ram loads, one to four bytes
    a_rd_ram: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_en && in_ram && !is_dbl) |=> !read_done [*2] ##1 read_done)
        else begin
            $error("narrow ram load timing wrong");
            fails++;
        end

    a_rd_dbl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_en && in_ram && is_dbl) |=> !read_done [*3] ##1 read_done)
        else begin
            $error("ld timing wrong");
            fails++;
        end

    a_wr_ram: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (write_en && in_ram && !is_dbl) |=> !write_done ##1 write_done)
        else begin
            $error("narrow ram store timing wrong");
            fails++;
        end

    a_wr_dbl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (write_en && in_ram && is_dbl) |=> !write_done [*2] ##1 write_done)
        else begin
            $error("sd timing wrong");
            fails++;
        end

    // keyboard, uart and unmapped, single cycle
    a_rd_io: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_en && !in_ram) |=> !read_done ##1 read_done)
        else begin
            $error("io read timing wrong");
            fails++;
        end

    a_wr_io: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (write_en && !in_ram) |=> !write_done ##1 write_done)
        else begin
            $error("io write timing wrong");
            fails++;
        end

    a_tx_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_valid |=> !tx_valid)
        else begin
            $error("tx_valid longer than one cycle");
            fails++;
        end

endmodule

`default_nettype wire

// ==== dv/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module soc_bus_tb;
    import board_pkg::*;

    logic      CLOCK_50;
    logic      KEY0;
    bus_req_t  req;
    logic      read_en;
    logic      write_en;
    bus_data_t rdata;
    logic      read_done;
    logic      write_done;
    logic      key_pressed;
    byte_t     key_ascii;
    logic      irq_ack;
    irq_vec_t  irq_vec;
    logic      tx_valid;
    byte_t     tx_data;

    integer    seed;
    integer    cycles;
    integer    tx_count;
    byte_t     tx_seen;
    byte_t     ref_mem [0:4095];

    soc_bus_top DUT (.*);

    bind soc_bus_top soc_bus_props u_props (
        .CLOCK_50(CLOCK_50), .KEY0(KEY0), .req(req), .read_en(read_en),
        .write_en(write_en), .read_done(read_done), .write_done(write_done),
        .tx_valid(tx_valid), .irq_vec(irq_vec)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // run limit, about 150 accesses of 4 cycles, doubled
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("timeout: the bus stopped completing accesses");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    // handshake and timing properties in the bound module
    always @(negedge CLOCK_50) begin
        if (DUT.u_props.fails != 0) begin
            $display("a handshake or timing assertion failed");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    // tx pulses seen between edges
    always @(negedge CLOCK_50) begin
        if (tx_valid) begin
            tx_count <= tx_count + 1;
            tx_seen  <= tx_data;
        end
    end

    task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // byte count of a load or store code
    function automatic int access_size(ls_type_e t);
        case (t)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // expected load from the byte model, little endian
    function automatic bus_data_t model_load(bus_addr_t a, ls_type_e t);
        bus_data_t v;
        int        n;
        n = access_size(t);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = ref_mem[a - `RAM_BASE + k];
        end
        if ((t == LB || t == LH || t == LW) && v[8*n-1]) begin
            v = v | (~64'd0 << (8*n));
        end
        return v;
    endfunction

    task automatic do_write(input bus_addr_t a, input ls_type_e t, input bus_data_t d);
        if (a >= `RAM_BASE && a < `RAM_BASE + 4096) begin
            for (int k = 0; k < access_size(t); k++) begin
                ref_mem[a - `RAM_BASE + k] = d[8*k +: 8];
            end
        end
        @(posedge CLOCK_50);
        req.addr    <= a;
        req.ls_type <= t;
        req.wdata   <= d;
        write_en    <= 1'b1;
        @(posedge CLOCK_50);
        write_en <= 1'b0;
        @(negedge CLOCK_50);
        while (!write_done) @(negedge CLOCK_50);
    endtask

    task automatic do_read(input bus_addr_t a, input ls_type_e t, output bus_data_t d);
        @(posedge CLOCK_50);
        req.addr    <= a;
        req.ls_type <= t;
        req.wdata   <= '0;
        read_en     <= 1'b1;
        @(posedge CLOCK_50);
        read_en <= 1'b0;
        @(negedge CLOCK_50);
        while (!read_done) @(negedge CLOCK_50);
        d = rdata;
    endtask

    // load and compare with the byte model
    task automatic load_check(input bus_addr_t a, input ls_type_e t);
        bus_data_t got;
        do_read(a, t, got);
        check_value("rdata", got, model_load(a, t));
    endtask

    initial begin
        bus_addr_t a;
        bus_data_t got;
        seed        = 61822;
        cycles      = 0;
        tx_count    = 0;
        tx_seen     = '0;
        KEY0        = 1'b0;
        req         = '0;
        read_en     = 1'b0;
        write_en    = 1'b0;
        key_pressed = 1'b0;
        key_ascii   = '0;
        irq_ack     = 1'b0;
        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // random sd and sw, then wide loads
        for (int i = 0; i < 12; i++) begin
            a = `RAM_BASE + 8 * ($unsigned($random(seed)) % 510);
            do_write(a, LD, {$random(seed), $random(seed)});
            do_write(a + 8, LW, 64'($random(seed)));
            load_check(a, LD);
            load_check(a, LW);
            load_check(a + 4, LWU);
            load_check(a + 8, LW);
            load_check(a + 8, LWU);
        end

        // narrow stores at every legal offset
        for (int i = 0; i < 4; i++) begin
            a = `RAM_BASE + 4 * ($unsigned($random(seed)) % 1024);
            do_write(a, LW, 64'($random(seed)));
            for (int k = 0; k < 4; k++) begin
                do_write(a + k, LB, 64'($random(seed)));
                load_check(a + k, LB);
                load_check(a + k, LBU);
            end
            for (int k = 0; k < 4; k += 2) begin
                do_write(a + k, LH, 64'($random(seed)));
                load_check(a + k, LH);
                load_check(a + k, LHU);
            end
            load_check(a, LW);
        end

        // keyboard press, read and interrupt ack
        @(posedge CLOCK_50);
        key_ascii   <= 8'h41;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
        check_value("irq_vec", 64'(irq_vec), 64'd1);
        do_read(`KEY_ADDR, LBU, got);
        check_value("key rdata", got, 64'h41);
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
        check_value("irq_vec", 64'(irq_vec), 64'd0);

        // console write, a single pulse
        do_write(`UART_ADDR, LB, 64'h1234_5678_9abc_de5a);
        repeat (3) @(negedge CLOCK_50);
        check_value("tx_count", 64'(tx_count), 64'd1);
        check_value("tx_data", 64'(tx_seen), 64'h5a);

        // unmapped read gives zero
        do_read(64'h0000_0000_0000_0800, LD, got);
        check_value("unmapped rdata", got, 64'd0);

        // let the last timing properties finish
        repeat (3) @(posedge CLOCK_50);

        if ((tx_count == 1) && (DUT.u_props.fails == 0)) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/board_pkg.sv
hdl/word_ram.sv
hdl/periph_regs.sv
hdl/bus_ctrl.sv
hdl/soc_bus_top.sv
dv/soc_bus_props.sv
dv/soc_bus_tb.sv
